// ==== mem_pkg.sv ====
/*
 * shared types for the RV32 memory side
 * word addressing only, so no byte offsets are carried anywhere
 */
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;   // data word
    typedef logic [31:0] addr_t;   // word address, not byte address
    typedef logic [3:0]  sel_t;    // wishbone byte lanes
    typedef logic [2:0]  func3_t;  // risc-v size/sign field

    // load/store size codes as they sit in the instruction
    localparam func3_t F3_B  = 3'b000;
    localparam func3_t F3_H  = 3'b001;
    localparam func3_t F3_W  = 3'b010;
    localparam func3_t F3_BU = 3'b100;
    localparam func3_t F3_HU = 3'b101;

    // wishbone classic master to slave, 71 bits
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        addr_t adr;
        word_t dat;
    } wb_req_t;

    // slave to master, 33 bits
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,   // waiting for go
        DATA,   // load or store cycle on the bus
        FETCH   // instruction word at pc
    } handler_state_t;

endpackage

`default_nettype wire

// ==== lsu_handler.sv ====
/*
 * load/store handler and the only wishbone master
 * every request ends with an instruction fetch at pc; core is frozen until then
 * assumes every slave acks one cycle after stb (no errors, no retries)
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_handler (
    input  logic             clk,
    input  logic             nrst,
    input  logic             go,
    input  logic             load,
    input  logic             store,
    input  mem_pkg::func3_t  func3,
    input  mem_pkg::addr_t   addr,
    input  mem_pkg::addr_t   pc,
    input  mem_pkg::word_t   store_data,
    input  mem_pkg::wb_rsp_t bus_rsp,
    output mem_pkg::wb_req_t bus_req,
    output mem_pkg::word_t   load_data,
    output mem_pkg::word_t   instr,
    output logic             instr_valid,
    output logic             freeze
);
    import mem_pkg::*;

    handler_state_t state;
    wb_req_t        req_q;   // registered bus request
    func3_t         f3_q;    // size of the pending load
    logic           load_q;  // data cycle was a load
    addr_t          pc_q;    // fetch address for after the data cycle
    logic           accept;

    // store byte lanes, low lanes only since there is no byte offset
    function automatic sel_t store_sel(input func3_t f3);
        case (f3)
            F3_B:    return 4'b0001;
            F3_H:    return 4'b0011;
            default: return 4'b1111;  // SW
        endcase
    endfunction

    // sign or zero extend the low part of the read word
    function automatic word_t size_load(input func3_t f3, input word_t w);
        case (f3)
            F3_B:    return {{24{w[7]}}, w[7:0]};
            F3_H:    return {{16{w[15]}}, w[15:0]};
            F3_BU:   return {24'b0, w[7:0]};
            F3_HU:   return {16'b0, w[15:0]};
            default: return w;                  // LW and anything unknown
        endcase
    endfunction

    // in IDLE freeze is just instr_valid, so a go in that cycle is dropped
    assign accept  = go && !freeze && (state == IDLE);
    assign freeze  = (state != IDLE) || instr_valid;
    assign bus_req = req_q;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state       <= IDLE;
            req_q       <= '0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;  // one cycle pulse
            case (state)
                IDLE: begin
                    if (accept) begin
                        req_q.cyc <= 1'b1;
                        req_q.stb <= 1'b1;
                        if (load || store) begin
                            state     <= DATA;
                            req_q.we  <= store;  // store wins if both set
                            req_q.sel <= store ? store_sel(func3) : 4'b1111;
                            req_q.adr <= addr;
                            req_q.dat <= store_data;
                        end else begin
                            state     <= FETCH;  // fetch-only request
                            req_q.we  <= 1'b0;
                            req_q.sel <= 4'b1111;
                            req_q.adr <= pc;
                            req_q.dat <= '0;
                        end
                    end
                end
                DATA: begin
                    if (bus_rsp.ack) begin
                        // straight into the fetch, cyc stays up
                        state     <= FETCH;
                        req_q.we  <= 1'b0;
                        req_q.sel <= 4'b1111;
                        req_q.adr <= pc_q;
                    end
                end
                FETCH: begin
                    if (bus_rsp.ack) begin
                        state       <= IDLE;
                        req_q.cyc   <= 1'b0;
                        req_q.stb   <= 1'b0;
                        instr_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields and returned words
    always_ff @(posedge clk) begin
        if (accept) begin
            f3_q   <= func3;
            load_q <= load && !store;
            pc_q   <= pc;
        end
        if (state == DATA && bus_rsp.ack && load_q) begin
            load_data <= size_load(f3_q, bus_rsp.dat);
        end
        if (state == FETCH && bus_rsp.ack) begin
            instr <= bus_rsp.dat;
        end
    end

endmodule

`default_nettype wire

// ==== wb_decoder.sv ====
/*
 * bank select for interleaved word memory
 * NUM_BANKS and BANK_WORDS must be powers of two, NUM_BANKS at least 2
 */
`timescale 1ns/1ps
`default_nettype none

module wb_decoder #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 256
) (
    input  mem_pkg::wb_req_t req,
    output mem_pkg::wb_req_t bank_req [NUM_BANKS],
    output logic             unmapped
);
    import mem_pkg::*;

    localparam int IDX_BITS  = $clog2(NUM_BANKS);
    localparam int WORD_BITS = $clog2(BANK_WORDS);

    logic [IDX_BITS-1:0] bank_idx;  // low address bits pick the bank
    addr_t               word_idx;  // address with bank bits removed
    logic                high_bits; // anything above the mapped range

    assign bank_idx  = req.adr[IDX_BITS-1:0];
    assign word_idx  = req.adr >> IDX_BITS;
    assign high_bits = |(req.adr >> (IDX_BITS + WORD_BITS));

    // resp mux acks these itself
    assign unmapped = req.cyc && req.stb && high_bits;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_req[i]     = req;       // cyc, we, sel, dat shared
            bank_req[i].adr = word_idx;
            // only the addressed bank sees stb
            bank_req[i].stb = req.stb && !high_bits && (bank_idx == IDX_BITS'(i));
        end
    end

endmodule

`default_nettype wire

// ==== ram_bank.sv ====
/*
 * one wishbone classic slave word memory, contents undefined after reset
 * ack is registered and lasts one cycle; read data is registered too
 * BANK_WORDS must be a power of two
 */
`timescale 1ns/1ps
`default_nettype none

module ram_bank #(
    parameter int BANK_WORDS = 256
) (
    input  logic             clk,
    input  logic             nrst,
    input  mem_pkg::wb_req_t req,
    output mem_pkg::wb_rsp_t rsp
);
    import mem_pkg::*;

    localparam int WORD_BITS = $clog2(BANK_WORDS);

    word_t                mem [BANK_WORDS];
    word_t                rd_q;     // read word for the ack cycle
    logic                 ack_q;
    logic [WORD_BITS-1:0] idx;
    logic                 access;   // first cycle of a strobe

    assign idx    = req.adr[WORD_BITS-1:0];  // decoder already stripped bank bits
    assign access = req.cyc && req.stb && !ack_q;

    // ack one cycle after stb, dropped in the cycle after ack
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // byte lane writes, read before write on the same word
    always_ff @(posedge clk) begin
        if (access) begin
            rd_q <= mem[idx];
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.sel[b]) begin
                        mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rd_q;

endmodule

`default_nettype wire

// ==== wb_resp_mux.sv ====
/*
 * merges bank responses back to the single master
 * an unmapped cycle gets one ack with zero data so the bus never hangs
 */
`timescale 1ns/1ps
`default_nettype none

module wb_resp_mux #(
    parameter int NUM_BANKS = 4
) (
    input  logic             clk,
    input  logic             nrst,
    input  mem_pkg::wb_rsp_t bank_rsp [NUM_BANKS],
    input  logic             unmapped,
    output mem_pkg::wb_rsp_t rsp
);
    import mem_pkg::*;

    logic unmapped_ack;  // stands in for the missing slave

    // same one-cycle ack rule as a bank
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= unmapped && !unmapped_ack;
        end
    end

    always_comb begin
        rsp.ack = unmapped_ack;
        rsp.dat = '0;  // zero for unmapped and idle
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_rsp[i].ack) begin  // at most one bank acks
                rsp.ack = 1'b1;
                rsp.dat = bank_rsp[i].dat;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_subsystem.sv ====
/*
 * memory side top level: handler, decoder, interleaved banks, response mux
 * fixed latency; 4 cycles go to instr_valid for load/store, 2 for fetch only
 */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 256
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            go,
    input  logic            load,
    input  logic            store,
    input  mem_pkg::func3_t func3,
    input  mem_pkg::addr_t  addr,
    input  mem_pkg::addr_t  pc,
    input  mem_pkg::word_t  store_data,
    output mem_pkg::word_t  load_data,
    output mem_pkg::word_t  instr,
    output logic            instr_valid,
    output logic            freeze
);
    import mem_pkg::*;

    wb_req_t bus_req;                // master side
    wb_rsp_t bus_rsp;
    wb_req_t bank_req [NUM_BANKS];   // per bank, stb already gated
    wb_rsp_t bank_rsp [NUM_BANKS];
    logic    unmapped;

    lsu_handler u_handler (
        .clk(clk), .nrst(nrst), .go(go), .load(load), .store(store),
        .func3(func3), .addr(addr), .pc(pc), .store_data(store_data),
        .bus_rsp(bus_rsp), .bus_req(bus_req), .load_data(load_data),
        .instr(instr), .instr_valid(instr_valid), .freeze(freeze)
    );

    wb_decoder #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_decoder (
        .req(bus_req), .bank_req(bank_req), .unmapped(unmapped)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        ram_bank #(.BANK_WORDS(BANK_WORDS)) u_bank (
            .clk(clk), .nrst(nrst), .req(bank_req[g]), .rsp(bank_rsp[g])
        );
    end

    wb_resp_mux #(.NUM_BANKS(NUM_BANKS)) u_resp_mux (
        .clk(clk), .nrst(nrst), .bank_rsp(bank_rsp),
        .unmapped(unmapped), .rsp(bus_rsp)
    );

endmodule

`default_nettype wire

// ==== mem_checker.sv ====
/*
 * wishbone handshake and freeze rules, bound into mem_subsystem
 * watches the single master port only
 */
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input logic             clk,
    input logic             nrst,
    input mem_pkg::wb_req_t bus_req,
    input mem_pkg::wb_rsp_t bus_rsp,
    input logic             freeze,
    input logic             instr_valid
);
    import mem_pkg::*;

    ack_needs_stb: assert property (@(posedge clk) disable iff (!nrst)
        bus_rsp.ack |-> bus_req.stb) else $error("ack seen without stb");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
        bus_rsp.ack |=> !bus_rsp.ack) else $error("ack held for two cycles");

    // master may only move adr once ack arrives
    adr_held: assert property (@(posedge clk) disable iff (!nrst)
        bus_req.stb && !bus_rsp.ack |=> $stable(bus_req.adr))
        else $error("adr changed while stb waited");

    freeze_in_cycle: assert property (@(posedge clk) disable iff (!nrst)
        bus_req.cyc |-> freeze) else $error("bus cycle with core not frozen");

    valid_pulse: assert property (@(posedge clk) disable iff (!nrst)
        instr_valid |=> !instr_valid) else $error("instr_valid longer than one cycle");

endmodule

bind mem_subsystem mem_checker u_checker (
    .clk(clk), .nrst(nrst), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .freeze(freeze), .instr_valid(instr_valid)
);

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
/*
 * directed tests for mem_subsystem against a word-array memory model
 * every fetch pc points at a word the tests have already written
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int NUM_BANKS    = 4;
    localparam int BANK_WORDS   = 256;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_NS       = 10;
    localparam int NUM_REQ      = 48;  // 46 requests below, rounded up

    logic   clk;
    logic   nrst;
    logic   go;
    logic   load;
    logic   store;
    func3_t func3;
    addr_t  addr;
    addr_t  pc;
    word_t  store_data;
    word_t  load_data;
    word_t  instr;
    logic   instr_valid;
    logic   freeze;

    word_t model [addr_t];  // expected memory, only written words

    mem_subsystem #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) uut (
        .clk(clk), .nrst(nrst), .go(go), .load(load), .store(store), .func3(func3),
        .addr(addr), .pc(pc), .store_data(store_data), .load_data(load_data),
        .instr(instr), .instr_valid(instr_valid), .freeze(freeze)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic logic is_mapped(input addr_t a);
        return a < NUM_BANKS * BANK_WORDS;
    endfunction

    // SB keeps the low lane of d, SH the low two, SW the whole word
    function automatic word_t merge_store(input func3_t f3, input word_t old, input word_t d);
        word_t mask;
        mask = (f3 == F3_B) ? 32'h0000_00ff : (f3 == F3_H) ? 32'h0000_ffff : 32'hffff_ffff;
        return (old & ~mask) | (d & mask);
    endfunction

    function automatic word_t expect_load(input func3_t f3, input word_t w);
        case (f3)
            F3_B:    return 32'($signed(w[7:0]));
            F3_H:    return 32'($signed(w[15:0]));
            F3_BU:   return 32'(w[7:0]);
            F3_HU:   return 32'(w[15:0]);
            default: return w;
        endcase
    endfunction

    // one request, go to instr_valid; latency, freeze and fetched word checked per cycle
    task automatic do_access(input string name, input logic ld, input logic st,
                             input func3_t f3, input addr_t a, input addr_t p,
                             input word_t d, input logic stray, input addr_t stray_a);
        int lat;
        int n;
        lat = (ld || st) ? 4 : 2;
        @(posedge clk);
        go         <= 1'b1;
        load       <= ld;
        store      <= st;
        func3      <= f3;
        addr       <= a;
        pc         <= p;
        store_data <= d;
        if (st && is_mapped(a)) begin
            model[a] = merge_store(f3, model.exists(a) ? model[a] : '0, d);
        end
        @(posedge clk);  // edge 0, go sampled
        go <= 1'b0;
        for (n = 1; n <= lat + 1; n++) begin
            @(posedge clk);
            if (stray && n == lat) begin
                go         <= 1'b1;  // second go in the instr_valid cycle, still frozen
                store      <= 1'b1;
                func3      <= F3_W;
                addr       <= stray_a;
                store_data <= ~d;
            end else begin
                go <= 1'b0;
            end
            @(negedge clk);
            check_flag({name, " instr_valid"}, n == lat, instr_valid);
            check_flag({name, " freeze"}, n <= lat, freeze);
        end
        check_word({name, " instr"}, model[p], instr);
    endtask

    task automatic store_to(input string name, input func3_t f3, input addr_t a,
                            input addr_t p, input word_t d);
        do_access(name, 1'b0, 1'b1, f3, a, p, d, 1'b0, '0);
    endtask

    task automatic load_and_check(input string name, input func3_t f3, input addr_t a,
                                  input addr_t p);
        word_t exp;
        do_access(name, 1'b1, 1'b0, f3, a, p, '0, 1'b0, '0);
        exp = is_mapped(a) ? expect_load(f3, model[a]) : '0;  // unmapped reads zero
        check_word({name, " load_data"}, exp, load_data);
    endtask

    // two random words per bank, each read back
    task automatic test_sw_lw();
        addr_t a;
        int    b;
        int    k;
        for (b = 0; b < NUM_BANKS; b++) begin
            for (k = 0; k < 2; k++) begin
                a = $urandom_range(BANK_WORDS - 1) * NUM_BANKS + b;  // low bits = bank
                store_to("sw_lw", F3_W, a, a, $urandom);
                load_and_check("sw_lw", F3_W, a, a);
            end
        end
    endtask

    task automatic test_sub_word_store();
        store_to("sub_store", F3_W, 32'd37, 32'd37, 32'h89ab_cdef);
        store_to("sub_store", F3_B, 32'd37, 32'd37, 32'h1234_5678);  // only 0x78 lands
        load_and_check("sub_store", F3_W, 32'd37, 32'd37);
        check_word("sub_store sb merge", 32'h89ab_cd78, load_data);
        store_to("sub_store", F3_H, 32'd37, 32'd37, 32'hfeed_0a0b);
        load_and_check("sub_store", F3_W, 32'd37, 32'd37);
        check_word("sub_store sh merge", 32'h89ab_0a0b, load_data);
    endtask

    // bit 7 and bit 15 set, mixed, then both clear
    task automatic test_load_extend();
        word_t  pats [3] = '{32'h0000_8081, 32'h1234_70f0, 32'hcafe_7f7f};
        func3_t codes [5] = '{F3_B, F3_H, F3_BU, F3_HU, F3_W};
        addr_t  a;
        for (int i = 0; i < 3; i++) begin
            a = 32'd600 + i;
            store_to("load_ext", F3_W, a, a, pats[i]);
            foreach (codes[j]) begin
                load_and_check("load_ext", codes[j], a, a);
            end
        end
    endtask

    task automatic test_fetch_only();
        addr_t pcs [4] = '{32'd37, 32'd600, 32'd601, 32'd602};
        foreach (pcs[i]) begin
            do_access("fetch_only", 1'b0, 1'b0, F3_W, '0, pcs[i], '0, 1'b0, '0);
        end
    endtask

    task automatic test_unmapped_and_freeze();
        addr_t far;
        far = 32'h0001_0000 | $urandom;  // bit 16 is above the mapped range
        load_and_check("unmapped", F3_W, far, 32'd37);
        do_access("freeze_go", 1'b1, 1'b0, F3_W, 32'd600, 32'd601, '0, 1'b1, 32'd602);
        check_word("freeze_go load_data", model[32'd600], load_data);
        load_and_check("freeze_go", F3_W, 32'd602, 32'd602);  // stray store left no trace
    endtask

    // watchdog, 8 cycles per request plus reset
    initial begin
        #((NUM_REQ * 8 + 2 * RESET_CYCLES) * CLK_NS);
        $display("timeout: the tests did not finish in the expected time");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(76380));
        clk        = 1'b0;
        nrst       = 1'b0;
        go         = 1'b0;
        load       = 1'b0;
        store      = 1'b0;
        func3      = F3_W;
        addr       = '0;
        pc         = '0;
        store_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_flag("reset instr_valid", 1'b0, instr_valid);
        check_flag("reset freeze", 1'b0, freeze);
        test_sw_lw();
        test_sub_word_store();
        test_load_extend();
        test_fetch_only();
        test_unmapped_and_freeze();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
mem_pkg.sv
lsu_handler.sv
wb_decoder.sv
ram_bank.sv
wb_resp_mux.sv
mem_subsystem.sv
mem_checker.sv
tb_mem_subsystem.sv
